// File: design/instr_queue.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module instr_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  rv32i_types::instr_t push_data,
    input  logic                pop,
    output rv32i_types::instr_t head,
    output logic                not_empty,
    output logic                not_full
);
    import rv32i_types::*;

    localparam logic [`IQ_CNT_W-1:0] full_count = `IQ_CNT_W'(`IQ_DEPTH);

    instr_t                mem [`IQ_DEPTH];
    logic [`IQ_PTR_W-1:0]  wr_ptr;
    logic [`IQ_PTR_W-1:0]  rd_ptr;
    logic [`IQ_CNT_W-1:0]  count;
    logic                  do_push;
    logic                  do_pop;

    assign not_empty = (count != '0);
    assign not_full  = (count != full_count);

    // only accept what the state allows
    assign do_push = push && not_full;
    assign do_pop  = pop && not_empty;

    // head word is visible without a read cycle
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own since depth is a power of two
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // the fetch side must respect not_full
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst) push |-> not_full
    ) else $error("instr_queue: push while full");

    // issue must never pop an empty queue
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst) pop |-> not_empty
    ) else $error("instr_queue: pop while empty");

endmodule

// File: design/issue.sv
`timescale 1ns/1ps

module issue (
    input  logic                instr_valid,
    input  logic                instr_ready,
    input  rv32i_types::instr_t head,
    issue_if.issuer             iss,
    output logic                instr_pop,
    output logic                issue_valid,
    output logic [4:0]          dispatch_rd,
    output logic [12:0]         dispatch_br_offset
);
    import rv32i_types::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic       is_alu;
    logic       is_mul;
    logic       is_branch;
    logic       is_cond_br;
    logic       can_issue;

    assign opcode = head.r_view.opcode;
    assign funct7 = head.r_view.funct7;

    // instruction class of the head word
    always_comb begin
        is_alu = (opcode == lui_opcode) || (opcode == auipc_opcode) ||
                 (opcode == imm_opcode) ||
                 ((opcode == reg_opcode) && (funct7 != multiply_funct7));
        is_mul = (opcode == reg_opcode) && (funct7 == multiply_funct7);
        is_branch = (opcode == br_opcode) || (opcode == jal_opcode) ||
                    (opcode == jalr_opcode);
        is_cond_br = (opcode == br_opcode);
    end

    // rob space, enable and a valid head gate every class
    assign can_issue = !iss.rob_full && instr_valid && instr_ready;

    always_comb begin
        iss.alu_rs_issue    = can_issue && is_alu && !iss.alu_rs_full;
        iss.mul_rs_issue    = can_issue && is_mul && !iss.mul_rs_full;
        iss.branch_rs_issue = can_issue && is_branch && !iss.branch_rs_full;
        iss.rob_push = iss.alu_rs_issue || iss.mul_rs_issue || iss.branch_rs_issue;
        instr_pop    = iss.rob_push;
        issue_valid  = iss.rob_push;
    end

    // conditional branches write no register
    assign dispatch_rd = (issue_valid && !is_cond_br) ? head.r_view.rd : 5'd0;

    // reassemble the B-type immediate, bit 0 always zero
    always_comb begin
        dispatch_br_offset = '0;
        if (iss.branch_rs_issue && is_cond_br) begin
            dispatch_br_offset = {head.b_view.imm_hi[6],
                                  head.b_view.imm_lo[0],
                                  head.b_view.imm_hi[5:0],
                                  head.b_view.imm_lo[4:1],
                                  1'b0};
        end
    end

    // decode classes are disjoint so one station at a time
    always_comb begin
        a_one_station: assert final (
            $onehot0({iss.alu_rs_issue, iss.mul_rs_issue, iss.branch_rs_issue})
        ) else $error("issue: more than one station strobe");
    end

endmodule

// File: design/issue_if.sv
`timescale 1ns/1ps

interface issue_if;

    // occupancy flags from the tracker
    logic alu_rs_full;
    logic mul_rs_full;
    logic branch_rs_full;
    logic rob_full;

    // dispatch strobes from issue
    logic alu_rs_issue;
    logic mul_rs_issue;
    logic branch_rs_issue;
    logic rob_push;

    modport tracker (
        output alu_rs_full, mul_rs_full, branch_rs_full, rob_full,
        input  alu_rs_issue, mul_rs_issue, branch_rs_issue, rob_push
    );

    modport issuer (
        input  alu_rs_full, mul_rs_full, branch_rs_full, rob_full,
        output alu_rs_issue, mul_rs_issue, branch_rs_issue, rob_push
    );

endinterface

// File: design/issue_macros.svh
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// instruction queue geometry
`define IQ_DEPTH 8
`define IQ_PTR_W 3
`define IQ_CNT_W 4

// reservation station capacities
`define ALU_RS_DEPTH 4
`define MUL_RS_DEPTH 2
`define BR_RS_DEPTH 2

// reorder buffer capacity
`define ROB_DEPTH 8

// occupancy counter width covering the largest depth
`define OCC_W 4

`endif

// File: design/issue_stage_top.sv
`timescale 1ns/1ps

module issue_stage_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_valid,
    input  logic [31:0] fetch_instr,
    input  logic        issue_en,
    input  logic        alu_rs_free,
    input  logic        mul_rs_free,
    input  logic        branch_rs_free,
    input  logic        rob_commit,
    output logic        fetch_ready,
    output logic        alu_rs_issue,
    output logic        mul_rs_issue,
    output logic        branch_rs_issue,
    output logic        issue_valid,
    output logic [4:0]  dispatch_rd,
    output logic [12:0] dispatch_br_offset
);
    import rv32i_types::*;

    instr_t head_word;
    logic   q_not_empty;
    logic   q_not_full;
    logic   q_pop;

    issue_if iss_bus ();

    instr_queue i_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (fetch_valid && q_not_full),
        .push_data (fetch_instr),
        .pop       (q_pop),
        .head      (head_word),
        .not_empty (q_not_empty),
        .not_full  (q_not_full)
    );

    rs_tracker i_tracker (
        .clk            (clk),
        .rst            (rst),
        .alu_rs_free    (alu_rs_free),
        .mul_rs_free    (mul_rs_free),
        .branch_rs_free (branch_rs_free),
        .rob_commit     (rob_commit),
        .iss            (iss_bus.tracker)
    );

    issue i_issue (
        .instr_valid        (q_not_empty),
        .instr_ready        (issue_en),
        .head               (head_word),
        .iss                (iss_bus.issuer),
        .instr_pop          (q_pop),
        .issue_valid        (issue_valid),
        .dispatch_rd        (dispatch_rd),
        .dispatch_br_offset (dispatch_br_offset)
    );

    assign fetch_ready     = q_not_full;
    assign alu_rs_issue    = iss_bus.alu_rs_issue;
    assign mul_rs_issue    = iss_bus.mul_rs_issue;
    assign branch_rs_issue = iss_bus.branch_rs_issue;

endmodule

// File: design/rs_tracker.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module rs_tracker (
    input  logic      clk,
    input  logic      rst,
    input  logic      alu_rs_free,
    input  logic      mul_rs_free,
    input  logic      branch_rs_free,
    input  logic      rob_commit,
    issue_if.tracker  iss
);

    // index 0 alu, 1 mul, 2 branch, 3 rob
    localparam int occ_depth [4] = '{`ALU_RS_DEPTH, `MUL_RS_DEPTH, `BR_RS_DEPTH, `ROB_DEPTH};

    logic [`OCC_W-1:0] occ [4];
    logic [3:0]        inc;
    logic [3:0]        free;
    logic [3:0]        full;

    assign inc  = {iss.rob_push, iss.branch_rs_issue, iss.mul_rs_issue, iss.alu_rs_issue};
    assign free = {rob_commit, branch_rs_free, mul_rs_free, alu_rs_free};

    for (genvar i = 0; i < 4; i++) begin : g_occ
        localparam logic [`OCC_W-1:0] cap = `OCC_W'(occ_depth[i]);

        logic dec_ok;

        // a free on an empty counter is dropped
        assign dec_ok = free[i] && (occ[i] != '0);

        always_ff @(posedge clk) begin
            if (rst) begin
                occ[i] <= '0;
            end else if (inc[i] && !dec_ok) begin
                occ[i] <= occ[i] + 1'b1;
            end else if (dec_ok && !inc[i]) begin
                occ[i] <= occ[i] - 1'b1;
            end
        end

        assign full[i] = (occ[i] == cap);

        // issue logic must stop at capacity
        a_within_cap: assert property (
            @(posedge clk) disable iff (rst) occ[i] <= cap
        ) else $error("rs_tracker: counter %0d above capacity", i);

        // the station or ROB never frees an entry it does not hold
        a_free_nonzero: assert property (
            @(posedge clk) disable iff (rst) free[i] |-> (occ[i] != '0)
        ) else $error("rs_tracker: free pulse on empty counter %0d", i);
    end

    assign iss.alu_rs_full    = full[0];
    assign iss.mul_rs_full    = full[1];
    assign iss.branch_rs_full = full[2];
    assign iss.rob_full       = full[3];

endmodule

// File: design/rv32i_types.sv
package rv32i_types;

    // major opcodes handled by dispatch
    localparam logic [6:0] lui_opcode   = 7'b0110111;
    localparam logic [6:0] auipc_opcode = 7'b0010111;
    localparam logic [6:0] imm_opcode   = 7'b0010011;
    localparam logic [6:0] reg_opcode   = 7'b0110011;
    localparam logic [6:0] br_opcode    = 7'b1100011;
    localparam logic [6:0] jal_opcode   = 7'b1101111;
    localparam logic [6:0] jalr_opcode  = 7'b1100111;

    // M extension marker in funct7 of reg-reg ops
    localparam logic [6:0] multiply_funct7 = 7'b0000001;

    // one instruction word seen as R-type or B-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        // branch immediate split across the word
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } b_view;
    } instr_t;

endpackage

// File: project.f
+incdir+design
design/rv32i_types.sv
design/issue_if.sv
design/instr_queue.sv
design/rs_tracker.sv
design/issue.sv
design/issue_stage_top.sv
testbench/tb_issue_stage.sv

// File: testbench/tb_issue_stage.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module tb_issue_stage;
    import rv32i_types::*;

    localparam int random_cycles  = 2000;
    localparam int drain_cycles   = 200;
    localparam int timeout_cycles = random_cycles + drain_cycles + 300;
    localparam int cap [4] = '{`ALU_RS_DEPTH, `MUL_RS_DEPTH, `BR_RS_DEPTH, `ROB_DEPTH};

    logic        clk;
    logic        rst;
    logic        fetch_valid;
    logic [31:0] fetch_instr;
    logic        issue_en;
    logic        alu_rs_free;
    logic        mul_rs_free;
    logic        branch_rs_free;
    logic        rob_commit;
    logic        fetch_ready;
    logic        alu_rs_issue;
    logic        mul_rs_issue;
    logic        branch_rs_issue;
    logic        issue_valid;
    logic [4:0]  dispatch_rd;
    logic [12:0] dispatch_br_offset;

    // reference model state
    logic [31:0] model_q [$];
    int          occ_model [4];
    int          exp_station;
    logic        exp_fetch_ready;
    logic [4:0]  exp_rd;
    logic [12:0] exp_offset;

    logic [31:0] rng_state;
    int          cycle_count;
    int          check_count;
    int          error_count;

    issue_stage_top i_dut (
        .clk                (clk),
        .rst                (rst),
        .fetch_valid        (fetch_valid),
        .fetch_instr        (fetch_instr),
        .issue_en           (issue_en),
        .alu_rs_free        (alu_rs_free),
        .mul_rs_free        (mul_rs_free),
        .branch_rs_free     (branch_rs_free),
        .rob_commit         (rob_commit),
        .fetch_ready        (fetch_ready),
        .alu_rs_issue       (alu_rs_issue),
        .mul_rs_issue       (mul_rs_issue),
        .branch_rs_issue    (branch_rs_issue),
        .issue_valid        (issue_valid),
        .dispatch_rd        (dispatch_rd),
        .dispatch_br_offset (dispatch_br_offset)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function logic chance(input int percent);
        return (next_rand() % 100) < percent;
    endfunction

    // legal classes only, other fields left random
    function logic [31:0] random_instr();
        logic [31:0] w;
        logic [2:0]  kind;
        kind = next_rand() % 8;
        w = next_rand();
        case (kind)
            3'd0: w[6:0] = lui_opcode;
            3'd1: w[6:0] = auipc_opcode;
            3'd2: w[6:0] = imm_opcode;
            3'd3: begin
                w[6:0] = reg_opcode;
                if (w[31:25] == 7'd1) begin
                    w[31:25] = 7'h20;
                end
            end
            3'd4: begin
                w[6:0] = reg_opcode;
                w[31:25] = 7'd1;
            end
            3'd5: w[6:0] = br_opcode;
            3'd6: w[6:0] = jal_opcode;
            default: w[6:0] = jalr_opcode;
        endcase
        return w;
    endfunction

    // 0 alu, 1 multiply, 2 branch
    function automatic int station_of(input logic [31:0] w);
        if (w[6:0] == br_opcode || w[6:0] == jal_opcode || w[6:0] == jalr_opcode) begin
            return 2;
        end
        if (w[6:0] == reg_opcode && w[31:25] == 7'd1) begin
            return 1;
        end
        return 0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH at %0t: %s expected 0x%0h got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic predict();
        logic [31:0] w;
        int          st;
        exp_station     = -1;
        exp_fetch_ready = (model_q.size() < `IQ_DEPTH);
        exp_rd          = '0;
        exp_offset      = '0;
        if (model_q.size() != 0 && issue_en && occ_model[3] < cap[3]) begin
            w  = model_q[0];
            st = station_of(w);
            if (occ_model[st] < cap[st]) begin
                exp_station = st;
                if (w[6:0] == br_opcode) begin
                    exp_offset = {w[31], w[7], w[30:25], w[11:8], 1'b0};
                end else begin
                    exp_rd = w[11:7];
                end
            end
        end
    endtask

    task automatic compare_outputs();
        check_value("fetch_ready", exp_fetch_ready, fetch_ready);
        check_value("alu_rs_issue", exp_station == 0, alu_rs_issue);
        check_value("mul_rs_issue", exp_station == 1, mul_rs_issue);
        check_value("branch_rs_issue", exp_station == 2, branch_rs_issue);
        check_value("issue_valid", exp_station >= 0, issue_valid);
        check_value("dispatch_rd", exp_rd, dispatch_rd);
        check_value("dispatch_br_offset", exp_offset, dispatch_br_offset);
    endtask

    // mirrors the clock edge using the inputs of the cycle just ended
    task automatic update_model();
        logic       push_ok;
        logic       inc;
        logic       dec;
        logic [3:0] free_vec;
        push_ok  = fetch_valid && (model_q.size() < `IQ_DEPTH);
        free_vec = {rob_commit, branch_rs_free, mul_rs_free, alu_rs_free};
        if (exp_station >= 0) begin
            void'(model_q.pop_front());
        end
        if (push_ok) begin
            model_q.push_back(fetch_instr);
        end
        for (int i = 0; i < 4; i++) begin
            inc = (i == 3) ? (exp_station >= 0) : (exp_station == i);
            dec = free_vec[i] && (occ_model[i] != 0);
            if (inc && !dec) begin
                occ_model[i]++;
            end else if (dec && !inc) begin
                occ_model[i]--;
            end
        end
    endtask

    task automatic drive_inputs(input logic drain);
        if (drain) begin
            fetch_valid    <= 1'b0;
            issue_en       <= 1'b1;
            alu_rs_free    <= (occ_model[0] != 0);
            mul_rs_free    <= (occ_model[1] != 0);
            branch_rs_free <= (occ_model[2] != 0);
            rob_commit     <= (occ_model[3] != 0);
        end else begin
            fetch_valid    <= chance(60);
            fetch_instr    <= random_instr();
            issue_en       <= chance(85);
            alu_rs_free    <= chance(30) && (occ_model[0] != 0);
            mul_rs_free    <= chance(30) && (occ_model[1] != 0);
            branch_rs_free <= chance(30) && (occ_model[2] != 0);
            rob_commit     <= chance(30) && (occ_model[3] != 0);
        end
    endtask

    initial begin
        wait (cycle_count == timeout_cycles);
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Verification failed");
        $finish;
    end

    initial begin
        rng_state      = 32'hc9adc7be;
        cycle_count    = 0;
        check_count    = 0;
        error_count    = 0;
        rst            = 1'b1;
        fetch_valid    = 1'b0;
        fetch_instr    = '0;
        issue_en       = 1'b0;
        alu_rs_free    = 1'b0;
        mul_rs_free    = 1'b0;
        branch_rs_free = 1'b0;
        rob_commit     = 1'b0;
        for (int i = 0; i < 4; i++) begin
            occ_model[i] = 0;
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // state right after reset
        @(negedge clk);
        predict();
        compare_outputs();

        for (int n = 0; n < random_cycles + drain_cycles; n++) begin
            @(posedge clk);
            update_model();
            drive_inputs(n >= random_cycles);
            @(negedge clk);
            predict();
            compare_outputs();
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
